//--- include/ldq_consts.svh
`ifndef LDQ_CONSTS_SVH
`define LDQ_CONSTS_SVH

// load queue
`define LDQ_SIZE    8
`define LDQ_IDX_W   3

// commit and rename ids
`define CMT_ID_W    6
`define RNID_W      6

// branch tracking
`define BRTAG_W     2
`define BR_MASK_W   4

// neighbour queues seen by the load queue
`define STQ_SIZE    8
`define LRQ_SIZE    4

// writeback ports into the queue
`define PHY_WR_NUM  2

`define VADDR_W     32

// sign-extended offset carried with a dispatched load
`define IMM_W       12

`endif

//--- logic/core_pkg.sv
`include "ldq_consts.svh"

package core_pkg;

  // load leaving rename
  typedef struct packed {
    logic                  rs1_valid;
    logic [`RNID_W-1:0]    rs1_rnid;
    logic                  rs2_valid;
    logic [`RNID_W-1:0]    rs2_rnid;
    logic [`BR_MASK_W-1:0] br_mask;
    logic [`CMT_ID_W-1:0]  cmt_id;
    logic [`IMM_W-1:0]     imm;
  } disp_t;

  // one physical register writeback port
  typedef struct packed {
    logic               valid;
    logic [`RNID_W-1:0] rnid;
  } phy_wr_t;

  typedef struct packed {
    logic                 commit;
    logic [`CMT_ID_W-1:0] cmt_id;
  } commit_t;

  // dead means the branch itself was killed
  typedef struct packed {
    logic                update;
    logic                mispredict;
    logic                dead;
    logic [`BRTAG_W-1:0] brtag;
  } br_upd_t;

endpackage

//--- logic/lsu_pkg.sv
`include "ldq_consts.svh"

package lsu_pkg;

  typedef enum logic [3:0] {
    INIT,
    ISSUE_WAIT,
    ISSUED,
    TLB_HAZ,
    EX2_RUN,
    LRQ_HAZ,
    STQ_HAZ,
    EX3_DONE,
    WAIT_COMPLETE,
    DEAD
  } ldq_state_t;

  typedef enum logic [2:0] {
    NONE,
    L1D_CONFLICT,
    LRQ_CONFLICT,
    LRQ_FULL,
    LRQ_ASSIGNED,
    STQ_DEPEND
  } hazard_t;

  // meaning depends on hazard_t
  typedef union packed {
    logic [`STQ_SIZE-1:0] stq_mask;
    struct packed {
      logic [`STQ_SIZE-`LRQ_SIZE-1:0] rsvd;
      logic [`LRQ_SIZE-1:0]           index_oh;
    } lrq;
  } haz_info_u;

  typedef struct packed {
    logic                  valid;
    logic [`LDQ_IDX_W-1:0] index;
    logic                  tlb_miss;
    logic                  except_valid;
    logic [`VADDR_W-1:0]   vaddr;
  } ex1_update_t;

  typedef struct packed {
    logic                  valid;
    logic [`LDQ_IDX_W-1:0] index;
    hazard_t               hazard;
    haz_info_u             haz_info;
  } ex2_update_t;

  typedef struct packed {
    logic                 valid;
    logic [`LRQ_SIZE-1:0] index_oh;
  } lrq_resolve_t;

  typedef struct packed {
    logic                 valid;
    logic [`STQ_SIZE-1:0] index_oh;
  } stq_resolve_t;

  typedef struct packed {
    logic                  is_valid;
    ldq_state_t            state;
    logic [`CMT_ID_W-1:0]  cmt_id;
    logic [`BR_MASK_W-1:0] br_mask;
    logic                  rs1_valid;
    logic                  rs1_ready;
    logic                  rs2_valid;
    logic                  rs2_ready;
    logic [`VADDR_W-1:0]   vaddr;
    logic                  except_valid;
    logic [`LRQ_SIZE-1:0]  lrq_haz_oh;
    logic [`STQ_SIZE-1:0]  stq_haz_mask;
  } ldq_entry_t;

endpackage

//--- logic/ldq_operand_wakeup.sv
`timescale 1ns/1ps
`include "ldq_consts.svh"

module ldq_operand_wakeup (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_load,
  input  logic               i_valid,
  input  logic [`RNID_W-1:0] i_rnid,
  input  core_pkg::phy_wr_t  i_phy_wr [`PHY_WR_NUM],
  output logic               o_ready
);

  logic               r_ready;
  logic [`RNID_W-1:0] r_rnid;
  logic [`RNID_W-1:0] w_rnid;
  logic               w_hit;

  assign w_rnid = i_load ? i_rnid : r_rnid;  // compare new tag in the load cycle

  always_comb begin
    w_hit = 1'b0;
    for (int b = 0; b < `PHY_WR_NUM; b++) begin
      w_hit = w_hit | (i_phy_wr[b].valid & (i_phy_wr[b].rnid == w_rnid));
    end
  end

  // unused operand counts as ready
  assign o_ready = i_load ? (~i_valid | w_hit) : (r_ready | w_hit);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ready <= 1'b0;
    end else begin
      r_ready <= o_ready;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_rnid <= i_rnid;
    end
  end

endmodule

//--- logic/ldq_pick.sv
`timescale 1ns/1ps
`include "ldq_consts.svh"

module ldq_pick (
  input  logic [`LDQ_SIZE-1:0]  i_ready,
  output logic                  o_valid,
  output logic [`LDQ_SIZE-1:0]  o_picked_oh,
  output logic [`LDQ_IDX_W-1:0] o_idx
);

  assign o_valid = |i_ready;

  // isolate lowest set bit
  assign o_picked_oh = i_ready & ~(i_ready - `LDQ_SIZE'(1));

  // one-hot to binary
  always_comb begin
    o_idx = '0;
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      if (o_picked_oh[i]) begin
        o_idx = o_idx | `LDQ_IDX_W'(i);
      end
    end
  end

endmodule

//--- logic/ldq_entry.sv
`timescale 1ns/1ps
`include "ldq_consts.svh"

module ldq_entry (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_disp_load,
  input  core_pkg::disp_t       i_disp,
  input  core_pkg::phy_wr_t     i_phy_wr [`PHY_WR_NUM],
  input  logic                  i_ex1_valid,
  input  lsu_pkg::ex1_update_t  i_ex1,
  input  logic                  i_ex2_valid,
  input  lsu_pkg::ex2_update_t  i_ex2,
  input  logic                  i_tlb_resolve,
  input  lsu_pkg::lrq_resolve_t i_lrq_resolve,
  input  lsu_pkg::stq_resolve_t i_stq_resolve,
  input  core_pkg::commit_t     i_commit,
  input  core_pkg::br_upd_t     i_br_upd,
  input  logic                  i_picked,
  output lsu_pkg::ldq_entry_t   o_entry,
  output logic                  o_ready,
  output logic                  o_finish
);
  import lsu_pkg::*;

  ldq_entry_t           r_entry;
  ldq_entry_t           w_entry_next;
  logic                 w_rs1_ready;
  logic                 w_rs2_ready;
  logic                 w_br_kill;
  logic                 w_br_flush;
  logic                 w_disp_br_flush;
  logic                 w_cmt_hit;
  logic                 w_lrq_match;
  logic [`STQ_SIZE-1:0] w_stq_clr;
  logic [`STQ_SIZE-1:0] w_stq_mask_next;
  logic [`STQ_SIZE-1:0] w_stq_mask_new;

  ldq_operand_wakeup u_rs1_wakeup (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_load    (i_disp_load),
    .i_valid   (i_disp.rs1_valid),
    .i_rnid    (i_disp.rs1_rnid),
    .i_phy_wr  (i_phy_wr),
    .o_ready   (w_rs1_ready)
  );

  ldq_operand_wakeup u_rs2_wakeup (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_load    (i_disp_load),
    .i_valid   (i_disp.rs2_valid),
    .i_rnid    (i_disp.rs2_rnid),
    .i_phy_wr  (i_phy_wr),
    .o_ready   (w_rs2_ready)
  );

  assign o_entry = r_entry;

  // live mispredict only
  assign w_br_kill       = i_br_upd.update & i_br_upd.mispredict & ~i_br_upd.dead;
  assign w_br_flush      = w_br_kill & r_entry.is_valid & r_entry.br_mask[i_br_upd.brtag];
  assign w_disp_br_flush = w_br_kill & i_disp.br_mask[i_br_upd.brtag];

  assign w_cmt_hit = i_commit.commit & (i_commit.cmt_id == r_entry.cmt_id);

  // hazard info decode
  assign w_lrq_match = i_lrq_resolve.valid &
                       (i_lrq_resolve.index_oh == i_ex2.haz_info.lrq.index_oh);

  assign w_stq_clr       = i_stq_resolve.valid ? i_stq_resolve.index_oh : '0;
  assign w_stq_mask_next = r_entry.stq_haz_mask & ~w_stq_clr;
  assign w_stq_mask_new  = i_ex2.haz_info.stq_mask & ~w_stq_clr;  // same-cycle store resolve

  // readiness is registered so a wakeup issues one cycle later
  assign o_ready = (r_entry.state == ISSUE_WAIT) & ~w_br_flush &
                   (~r_entry.rs1_valid | r_entry.rs1_ready) &
                   (~r_entry.rs2_valid | r_entry.rs2_ready);

  assign o_finish = w_cmt_hit & ((r_entry.state == WAIT_COMPLETE) | (r_entry.state == DEAD));

  always_comb begin
    w_entry_next = r_entry;

    case (r_entry.state)
      INIT: begin
        if (i_disp_load) begin
          w_entry_next.is_valid     = 1'b1;
          w_entry_next.state        = w_disp_br_flush ? DEAD : ISSUE_WAIT;
          w_entry_next.cmt_id       = i_disp.cmt_id;
          w_entry_next.br_mask      = i_disp.br_mask;
          w_entry_next.rs1_valid    = i_disp.rs1_valid;
          w_entry_next.rs2_valid    = i_disp.rs2_valid;
          w_entry_next.vaddr        = '0;
          w_entry_next.except_valid = 1'b0;
          w_entry_next.lrq_haz_oh   = '0;
          w_entry_next.stq_haz_mask = '0;
        end
      end
      ISSUE_WAIT: begin
        if (w_br_flush) begin
          w_entry_next.state = DEAD;
        end else if (o_ready & i_picked) begin
          w_entry_next.state = ISSUED;
        end
      end
      ISSUED: begin
        if (w_br_flush) begin
          w_entry_next.state = DEAD;
        end else if (i_ex1_valid) begin
          w_entry_next.state        = i_ex1.tlb_miss ? TLB_HAZ : EX2_RUN;
          w_entry_next.except_valid = i_ex1.except_valid;
          w_entry_next.vaddr        = i_ex1.vaddr;
        end
      end
      TLB_HAZ: begin
        if (w_br_flush) begin
          w_entry_next.state = DEAD;
        end else if (i_tlb_resolve) begin
          w_entry_next.state = ISSUE_WAIT;
        end
      end
      EX2_RUN: begin
        if (w_br_flush) begin
          w_entry_next.state = DEAD;
        end else if (i_ex2_valid) begin
          case (i_ex2.hazard)
            L1D_CONFLICT, LRQ_ASSIGNED: w_entry_next.state = ISSUE_WAIT;  // plain replay
            LRQ_CONFLICT, LRQ_FULL: begin
              w_entry_next.state      = w_lrq_match ? ISSUE_WAIT : LRQ_HAZ;
              w_entry_next.lrq_haz_oh = i_ex2.haz_info.lrq.index_oh;
            end
            STQ_DEPEND: begin
              w_entry_next.state        = STQ_HAZ;
              w_entry_next.stq_haz_mask = w_stq_mask_new;
            end
            default: w_entry_next.state = EX3_DONE;
          endcase
        end
      end
      LRQ_HAZ: begin
        if (w_br_flush) begin
          w_entry_next.state = DEAD;
        end else if (i_lrq_resolve.valid &&
                     i_lrq_resolve.index_oh == r_entry.lrq_haz_oh) begin
          w_entry_next.state = ISSUE_WAIT;
        end
      end
      STQ_HAZ: begin
        if (w_br_flush) begin
          w_entry_next.state = DEAD;
        end else begin
          w_entry_next.stq_haz_mask = w_stq_mask_next;
          if (w_stq_mask_next == '0) begin
            w_entry_next.state = ISSUE_WAIT;
          end
        end
      end
      EX3_DONE: begin
        w_entry_next.state = w_br_flush ? DEAD : WAIT_COMPLETE;
      end
      WAIT_COMPLETE, DEAD: begin
        if (w_cmt_hit) begin
          w_entry_next.state    = INIT;
          w_entry_next.is_valid = 1'b0;
        end else if (w_br_flush) begin
          w_entry_next.state = DEAD;
        end
      end
      default: w_entry_next.state = INIT;
    endcase

    w_entry_next.rs1_ready = w_rs1_ready;
    w_entry_next.rs2_ready = w_rs2_ready;

    // resolved tag is free for reuse
    if (i_br_upd.update) begin
      w_entry_next.br_mask[i_br_upd.brtag] = 1'b0;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_entry.is_valid <= 1'b0;
      r_entry.state    <= INIT;
    end else begin
      r_entry <= w_entry_next;
    end
  end

endmodule

//--- logic/ldq_top.sv
`timescale 1ns/1ps
`include "ldq_consts.svh"

module ldq_top (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_disp_valid,
  input  core_pkg::disp_t       i_disp,
  input  core_pkg::phy_wr_t     i_phy_wr [`PHY_WR_NUM],
  input  lsu_pkg::ex1_update_t  i_ex1,
  input  lsu_pkg::ex2_update_t  i_ex2,
  input  logic                  i_tlb_resolve,
  input  lsu_pkg::lrq_resolve_t i_lrq_resolve,
  input  lsu_pkg::stq_resolve_t i_stq_resolve,
  input  core_pkg::commit_t     i_commit,
  input  core_pkg::br_upd_t     i_br_upd,
  output logic                  o_disp_full,
  output logic                  o_issue_valid,
  output logic [`LDQ_IDX_W-1:0] o_issue_idx,
  output logic                  o_finish_valid,
  output logic [`LDQ_IDX_W-1:0] o_finish_idx
);
  import lsu_pkg::*;

  ldq_entry_t          w_entries [`LDQ_SIZE];
  logic [`LDQ_SIZE-1:0] w_valid;
  logic [`LDQ_SIZE-1:0] w_free_oh;
  logic [`LDQ_SIZE-1:0] w_disp_load;
  logic [`LDQ_SIZE-1:0] w_ex1_hit;
  logic [`LDQ_SIZE-1:0] w_ex2_hit;
  logic [`LDQ_SIZE-1:0] w_ready;
  logic [`LDQ_SIZE-1:0] w_picked_oh;
  logic [`LDQ_SIZE-1:0] w_finish;

  assign o_disp_full = &w_valid;

  // lowest free slot takes the dispatch
  always_comb begin
    w_free_oh = '0;
    for (int i = `LDQ_SIZE-1; i >= 0; i--) begin
      if (!w_valid[i]) begin
        w_free_oh    = '0;
        w_free_oh[i] = 1'b1;
      end
    end
  end

  for (genvar e = 0; e < `LDQ_SIZE; e++) begin : g_entry
    assign w_valid[e]     = w_entries[e].is_valid;
    assign w_disp_load[e] = i_disp_valid & w_free_oh[e];
    assign w_ex1_hit[e]   = i_ex1.valid & (i_ex1.index == `LDQ_IDX_W'(e));
    assign w_ex2_hit[e]   = i_ex2.valid & (i_ex2.index == `LDQ_IDX_W'(e));

    ldq_entry u_entry (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_disp_load   (w_disp_load[e]),
      .i_disp        (i_disp),
      .i_phy_wr      (i_phy_wr),
      .i_ex1_valid   (w_ex1_hit[e]),
      .i_ex1         (i_ex1),
      .i_ex2_valid   (w_ex2_hit[e]),
      .i_ex2         (i_ex2),
      .i_tlb_resolve (i_tlb_resolve),
      .i_lrq_resolve (i_lrq_resolve),
      .i_stq_resolve (i_stq_resolve),
      .i_commit      (i_commit),
      .i_br_upd      (i_br_upd),
      .i_picked      (w_picked_oh[e]),
      .o_entry       (w_entries[e]),
      .o_ready       (w_ready[e]),
      .o_finish      (w_finish[e])
    );
  end

  ldq_pick u_pick (
    .i_ready     (w_ready),
    .o_valid     (o_issue_valid),
    .o_picked_oh (w_picked_oh),
    .o_idx       (o_issue_idx)
  );

  assign o_finish_valid = |w_finish;

  always_comb begin
    o_finish_idx = '0;
    for (int i = `LDQ_SIZE-1; i >= 0; i--) begin
      if (w_finish[i]) begin
        o_finish_idx = `LDQ_IDX_W'(i);  // lowest wins
      end
    end
  end

endmodule

//--- sim/ldq_assertions.sv
`timescale 1ns/1ps
`include "ldq_consts.svh"

module ldq_assertions (
  input logic                  i_clk,
  input logic                  i_reset_n,
  input logic                  i_issue_valid,
  input logic [`LDQ_IDX_W-1:0] i_issue_idx,
  input logic                  i_finish_valid,
  input logic [`LDQ_SIZE-1:0]  i_valid
);

  // entries are all INIT while reset is held
  a_no_issue_in_reset: assert property (
    @(posedge i_clk) !i_reset_n |-> !i_issue_valid
  ) else $error("issue offered while in reset");

  a_issue_idx_live: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_issue_valid |-> (!$isunknown(i_issue_idx) && i_valid[i_issue_idx])
  ) else $error("issue index %0d does not name a valid entry", i_issue_idx);

  a_finish_needs_entry: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_finish_valid |-> (|i_valid)
  ) else $error("finish raised with an empty queue");

endmodule

bind ldq_top ldq_assertions u_assertions (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_issue_valid  (o_issue_valid),
  .i_issue_idx    (o_issue_idx),
  .i_finish_valid (o_finish_valid),
  .i_valid        (w_valid)
);

//--- sim/ldq_tb.sv
`timescale 1ns/1ps
`include "ldq_consts.svh"

module ldq_tb;
  import core_pkg::*;
  import lsu_pkg::*;

  typedef struct packed {
    logic       op_ready;    // operand hits in the dispatch cycle
    logic [3:0] wake_delay;  // idle cycles before the late writeback
    logic       tlb_miss;
    hazard_t    hazard;
    logic [1:0] br_mode;     // 0 none, 1 kill by own tag, 2 other tag
  } scen_t;

  localparam int NUM_SCEN = 10;
  localparam int WATCHDOG_CYCLES = NUM_SCEN * 60;

  localparam scen_t SCEN [NUM_SCEN] = '{
    '{1'b1, 4'd0, 1'b0, NONE,         2'd0},
    '{1'b0, 4'd3, 1'b0, NONE,         2'd0},
    '{1'b1, 4'd0, 1'b1, NONE,         2'd0},
    '{1'b1, 4'd0, 1'b0, L1D_CONFLICT, 2'd0},
    '{1'b0, 4'd1, 1'b0, LRQ_ASSIGNED, 2'd0},
    '{1'b1, 4'd0, 1'b0, LRQ_CONFLICT, 2'd0},
    '{1'b0, 4'd2, 1'b0, LRQ_FULL,     2'd0},
    '{1'b1, 4'd0, 1'b0, STQ_DEPEND,   2'd0},
    '{1'b0, 4'd2, 1'b0, NONE,         2'd1},
    '{1'b0, 4'd2, 1'b0, STQ_DEPEND,   2'd2}
  };

  logic                  clk;
  logic                  reset_n;
  logic                  disp_valid;
  disp_t                 disp_bus;
  phy_wr_t               phy_wr [`PHY_WR_NUM];
  ex1_update_t           ex1_bus;
  ex2_update_t           ex2_bus;
  logic                  tlb_resolve;
  lrq_resolve_t          lrq_bus;
  stq_resolve_t          stq_bus;
  commit_t               cmt_bus;
  br_upd_t               br_bus;
  logic                  disp_full;
  logic                  issue_valid;
  logic [`LDQ_IDX_W-1:0] issue_idx;
  logic                  finish_valid;
  logic [`LDQ_IDX_W-1:0] finish_idx;

  logic [`LDQ_SIZE-1:0]  occupied;  // slots holding a load
  int                    n_checks;
  int                    n_errors;

  ldq_top UUT (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_disp_valid   (disp_valid),
    .i_disp         (disp_bus),
    .i_phy_wr       (phy_wr),
    .i_ex1          (ex1_bus),
    .i_ex2          (ex2_bus),
    .i_tlb_resolve  (tlb_resolve),
    .i_lrq_resolve  (lrq_bus),
    .i_stq_resolve  (stq_bus),
    .i_commit       (cmt_bus),
    .i_br_upd       (br_bus),
    .o_disp_full    (disp_full),
    .o_issue_valid  (issue_valid),
    .o_issue_idx    (issue_idx),
    .o_finish_valid (finish_valid),
    .o_finish_idx   (finish_idx)
  );

  always #5 clk = ~clk;

  function automatic logic [`LDQ_IDX_W-1:0] lowest_free(input logic [`LDQ_SIZE-1:0] occ);
    logic [`LDQ_IDX_W-1:0] idx;
    logic                  found;
    idx = '0;
    found = 1'b0;
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      if (!found && !occ[i]) begin
        idx = `LDQ_IDX_W'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  task automatic expect_idle();
    @(negedge clk);
    n_checks++;
    if (issue_valid !== 1'b0) begin
      n_errors++;
      $display("FAIL %0t: unexpected issue of entry %0d", $time, issue_idx);
    end
    if (finish_valid !== 1'b0) begin
      n_errors++;
      $display("FAIL %0t: unexpected finish of entry %0d", $time, finish_idx);
    end
    if (disp_full !== &occupied) begin
      n_errors++;
      $display("FAIL %0t: disp_full %b, expected %b", $time, disp_full, &occupied);
    end
  endtask

  task automatic expect_issue(input logic [`LDQ_IDX_W-1:0] idx);
    @(negedge clk);
    n_checks++;
    if (issue_valid !== 1'b1) begin
      n_errors++;
      $display("FAIL %0t: no issue offered, expected entry %0d", $time, idx);
    end else if (issue_idx !== idx) begin
      n_errors++;
      $display("FAIL %0t: issue index %0d, expected %0d", $time, issue_idx, idx);
    end
  endtask

  task automatic expect_finish(input logic [`LDQ_IDX_W-1:0] idx);
    @(negedge clk);
    n_checks++;
    if (finish_valid !== 1'b1) begin
      n_errors++;
      $display("FAIL %0t: no finish on commit, expected entry %0d", $time, idx);
    end else if (finish_idx !== idx) begin
      n_errors++;
      $display("FAIL %0t: finish index %0d, expected %0d", $time, finish_idx, idx);
    end
  endtask

  // starts in the issue cycle and returns in the cycle after EX1
  task automatic send_ex1(input logic [`LDQ_IDX_W-1:0] slot, input logic miss);
    @(posedge clk);
    ex1_bus <= '{valid: 1'b1, index: slot, tlb_miss: miss, except_valid: 1'b0,
                 vaddr: `VADDR_W'($urandom)};
    expect_idle();
    @(posedge clk);
    ex1_bus <= '0;
  endtask

  task automatic play_tlb_miss(input logic [`LDQ_IDX_W-1:0] slot);
    send_ex1(slot, 1'b1);
    expect_idle();
    @(posedge clk);
    tlb_resolve <= 1'b1;
    expect_idle();
    @(posedge clk);
    tlb_resolve <= 1'b0;
    expect_issue(slot);
  endtask

  task automatic play_ex2_hazard(input logic [`LDQ_IDX_W-1:0] slot, input hazard_t hz,
                                 input haz_info_u info);
    logic [`LRQ_SIZE-1:0] other_oh;
    other_oh = (info.lrq.index_oh << 1) | (info.lrq.index_oh >> (`LRQ_SIZE - 1));
    send_ex1(slot, 1'b0);
    ex2_bus <= '{valid: 1'b1, index: slot, hazard: hz, haz_info: info};
    expect_idle();
    @(posedge clk);
    ex2_bus <= '0;
    case (hz)
      LRQ_CONFLICT, LRQ_FULL: begin
        lrq_bus <= '{valid: 1'b1, index_oh: other_oh};  // not ours
        expect_idle();
        @(posedge clk);
        lrq_bus <= '{valid: 1'b1, index_oh: info.lrq.index_oh};
        expect_idle();
        @(posedge clk);
        lrq_bus <= '0;
      end
      STQ_DEPEND: begin
        for (int b = 0; b < `STQ_SIZE; b++) begin
          if (info.stq_mask[b]) begin
            stq_bus <= '{valid: 1'b1, index_oh: `STQ_SIZE'(1) << b};
            expect_idle();
            @(posedge clk);
          end
        end
        stq_bus <= '0;
      end
      default: ;  // plain replay
    endcase
    expect_issue(slot);
  endtask

  task automatic play_to_commit(input logic [`LDQ_IDX_W-1:0] slot,
                                input logic [`CMT_ID_W-1:0] cmt_id);
    send_ex1(slot, 1'b0);
    ex2_bus <= '{valid: 1'b1, index: slot, hazard: NONE, haz_info: '0};
    expect_idle();
    @(posedge clk);
    ex2_bus <= '0;
    expect_idle();  // EX3_DONE
    @(posedge clk);
    cmt_bus <= '{commit: 1'b1, cmt_id: cmt_id};
    expect_finish(slot);
    @(posedge clk);
    cmt_bus <= '0;
    occupied[slot] = 1'b0;
    expect_idle();
  endtask

  task automatic run_scenario(input int s);
    scen_t                 sc;
    disp_t                 ld;
    logic [`RNID_W-1:0]    rnid;
    logic [`LDQ_IDX_W-1:0] slot;
    logic [`CMT_ID_W-1:0]  cmt_id;
    haz_info_u             info;
    sc = SCEN[s];
    rnid = `RNID_W'($urandom);
    slot = lowest_free(occupied);
    cmt_id = `CMT_ID_W'(s + 1);
    info = '0;
    if (sc.hazard == STQ_DEPEND) begin
      info.stq_mask = `STQ_SIZE'($urandom) | `STQ_SIZE'(1);  // never empty
    end else begin
      info.lrq.index_oh = `LRQ_SIZE'(1) << ($urandom % `LRQ_SIZE);
    end
    ld = '0;
    ld.rs1_valid = 1'b1;
    ld.rs1_rnid = rnid;
    ld.br_mask = `BR_MASK_W'(2);  // under branch tag 1
    ld.cmt_id = cmt_id;
    ld.imm = `IMM_W'($urandom);

    @(posedge clk);
    disp_valid <= 1'b1;
    disp_bus <= ld;
    if (sc.op_ready) begin
      phy_wr[1] <= '{valid: 1'b1, rnid: rnid};
    end
    expect_idle();
    @(posedge clk);
    disp_valid <= 1'b0;
    phy_wr[1] <= '0;
    occupied[slot] = 1'b1;

    if (!sc.op_ready) begin
      if (sc.br_mode != 2'd0) begin
        br_bus <= '{update: 1'b1, mispredict: 1'b1, dead: 1'b0,
                    brtag: (sc.br_mode == 2'd1) ? `BRTAG_W'(1) : `BRTAG_W'(2)};
      end
      repeat (sc.wake_delay) begin
        expect_idle();
        @(posedge clk);
        br_bus <= '0;
      end
      phy_wr[0] <= '{valid: 1'b1, rnid: rnid};
      expect_idle();
      @(posedge clk);
      phy_wr[0] <= '0;
      br_bus <= '0;
    end

    if (sc.br_mode == 2'd1) begin
      // killed entry stays silent until its commit
      repeat (3) begin
        expect_idle();
        @(posedge clk);
      end
      cmt_bus <= '{commit: 1'b1, cmt_id: cmt_id};
      expect_finish(slot);
      @(posedge clk);
      cmt_bus <= '0;
      occupied[slot] = 1'b0;
      expect_idle();
    end else begin
      expect_issue(slot);
      if (sc.tlb_miss) begin
        play_tlb_miss(slot);
      end
      if (sc.hazard != NONE) begin
        play_ex2_hazard(slot, sc.hazard, info);
      end
      play_to_commit(slot, cmt_id);
    end
  endtask

  task automatic fill_queue();
    disp_t                 ld;
    logic [`LDQ_IDX_W-1:0] slot;
    logic [`LDQ_IDX_W-1:0] victim;
    victim = `LDQ_IDX_W'($urandom);
    for (int k = 0; k < `LDQ_SIZE; k++) begin
      slot = lowest_free(occupied);
      ld = '0;
      ld.rs1_valid = 1'b1;
      ld.rs1_rnid = `RNID_W'(32 + int'(slot));  // rnid tells the slot apart
      ld.cmt_id = `CMT_ID_W'(32 + int'(slot));
      @(posedge clk);
      disp_valid <= 1'b1;
      disp_bus <= ld;
      expect_idle();
      @(posedge clk);
      disp_valid <= 1'b0;
      occupied[slot] = 1'b1;
      expect_idle();
    end
    @(posedge clk);
    phy_wr[0] <= '{valid: 1'b1, rnid: `RNID_W'(32 + int'(victim))};
    expect_idle();
    @(posedge clk);
    phy_wr[0] <= '0;
    expect_issue(victim);
    play_to_commit(victim, `CMT_ID_W'(32 + int'(victim)));
  endtask

  initial begin
    clk = 1'b0;
    reset_n = 1'b0;
    disp_valid = 1'b0;
    disp_bus = '0;
    for (int b = 0; b < `PHY_WR_NUM; b++) begin
      phy_wr[b] = '0;
    end
    ex1_bus = '0;
    ex2_bus = '0;
    tlb_resolve = 1'b0;
    lrq_bus = '0;
    stq_bus = '0;
    cmt_bus = '0;
    br_bus = '0;
    occupied = '0;
    n_checks = 0;
    n_errors = 0;
    void'($urandom(32'hf6c024e3));

    repeat (3) @(posedge clk);
    expect_idle();
    @(posedge clk);
    reset_n <= 1'b1;
    expect_idle();

    for (int s = 0; s < NUM_SCEN; s++) begin
      run_scenario(s);
    end
    fill_queue();

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- all.f
+incdir+include
logic/core_pkg.sv
logic/lsu_pkg.sv
logic/ldq_operand_wakeup.sv
logic/ldq_pick.sv
logic/ldq_entry.sv
logic/ldq_top.sv
sim/ldq_assertions.sv
sim/ldq_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ldq_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
